/* src/pitch_config.svh */
// Size and format constants for the time-stretch core
// PITCH_HOP must stay equal to PITCH_WINDOW / 2
// Samples are signed 16 bit, and the coefficients are unsigned Q0.15
`ifndef PITCH_CONFIG_SVH
`define PITCH_CONFIG_SVH

`define PITCH_ADDR_W    23  // SDRAM word address
`define PITCH_DATA_W    32  // SDRAM word, one stereo pair
`define PITCH_SAMPLE_W  16  // Per channel

`define PITCH_WINDOW    64  // Frame length in stereo words
`define PITCH_HOP       32  // Synthesis hop
`define PITCH_IDX_W     6   // Index into one frame

`define PITCH_COEF_W    16  // Hann coefficient, Q0.15
`define PITCH_SPEED_W   4   // Speed ratio in eighths

`endif

/* src/pitch_pkg.sv */
// Types shared by the time-stretch blocks
// Q0.15 cannot hold 1.0, so the Hann peak saturates to 32767
// hann_coeff is meant for elaboration-time ROM contents only
`include "pitch_config.svh"

package pitch_pkg;

    // Header view: sample count in the low bits
    typedef struct packed {
        logic [`PITCH_DATA_W-`PITCH_ADDR_W-1:0] pad;     // 9 unused bits
        logic [`PITCH_ADDR_W-1:0]               length;
    } header_t;

    // Sample view: left channel in the upper half
    typedef struct packed {
        logic signed [`PITCH_SAMPLE_W-1:0] left;
        logic signed [`PITCH_SAMPLE_W-1:0] right;
    } stereo_t;

    typedef union packed {
        header_t hdr;
        stereo_t pair;
    } sdram_word_u;

    function automatic logic [`PITCH_COEF_W-1:0] hann_coeff(input int n);
        real w;
        int  c;
        w = 0.5 - 0.5 * $cos(2.0 * 3.14159265358979 * n / `PITCH_WINDOW);
        c = int'(w * 32768.0);  // Round to nearest
        if (c > 32767) begin
            c = 32767;          // Peak at n = WINDOW/2
        end
        return c[`PITCH_COEF_W-1:0];
    endfunction

endpackage

/* src/frame_reader.sv */
// Frame producer that reads the header, steps the analysis hop and fills the buffer
// Speed 0 gives H_a = 0 and the run never ends
// The buffer is refilled only after frame_written from the writer
`timescale 1ns/10ps
`include "pitch_config.svh"

module frame_reader (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic [`PITCH_ADDR_W-1:0]  src_addr,
    input  logic [`PITCH_SPEED_W-1:0] speed,
    input  pitch_pkg::sdram_word_u    sdram_readdata,
    input  logic                      sdram_finished,
    input  logic                      frame_written,
    output logic                      sdram_read,
    output logic [`PITCH_ADDR_W-1:0]  rd_addr,
    output logic                      fill_we,
    output logic [`PITCH_IDX_W-1:0]   fill_idx,
    output pitch_pkg::sdram_word_u    fill_data,
    output logic                      frame_full,
    output logic                      done
);
    localparam int HA_W = `PITCH_IDX_W + 1;   // H_a up to 60

    typedef enum logic [1:0] {S_IDLE, S_HDR, S_FILL, S_WAIT} state_t;
    state_t state;

    logic [`PITCH_ADDR_W-1:0] length;      // Sample words after the header
    logic [`PITCH_ADDR_W-1:0] base;        // src + 1 + k*H_a
    logic [`PITCH_ADDR_W-1:0] frame_off;   // k*H_a
    logic [`PITCH_ADDR_W-1:0] next_base;
    logic [HA_W-1:0]          h_a;
    logic [`PITCH_ADDR_W:0]   chk_off;     // Offset of the frame under test
    logic [`PITCH_ADDR_W:0]   chk_len;
    logic                     fits;

    // First test uses the header word as it arrives
    always_comb begin
        if (state == S_HDR) begin
            chk_off = '0;
            chk_len = {1'b0, sdram_readdata.hdr.length};
        end else begin
            chk_off = {1'b0, frame_off} + h_a;   // Next frame
            chk_len = {1'b0, length};
        end
    end

    assign fits      = (chk_off + `PITCH_WINDOW) <= chk_len;
    assign next_base = base + h_a;
    assign fill_we   = (state == S_FILL) && sdram_finished;   // Store on completion
    assign fill_data = sdram_readdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            sdram_read <= 1'b0;
            rd_addr    <= '0;
            fill_idx   <= '0;
            frame_full <= 1'b0;
            done       <= 1'b0;
            h_a        <= '0;
            length     <= '0;
            base       <= '0;
            frame_off  <= '0;
        end else begin
            frame_full <= fill_we && (fill_idx == `PITCH_IDX_W'(`PITCH_WINDOW - 1));
            done       <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        sdram_read <= 1'b1;           // Header request
                        rd_addr    <= src_addr;
                        base       <= src_addr + 1'b1;
                        h_a        <= HA_W'((`PITCH_HOP * speed) >> 3);
                        fill_idx   <= '0;
                        state      <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (sdram_finished) begin
                        length    <= sdram_readdata.hdr.length;
                        frame_off <= '0;
                        if (fits) begin
                            rd_addr <= base;          // Frame 0 with the read held high
                            state   <= S_FILL;
                        end else begin
                            sdram_read <= 1'b0;       // Too short for one frame
                            done       <= 1'b1;
                            state      <= S_IDLE;
                        end
                    end
                end
                S_FILL: begin
                    if (sdram_finished) begin
                        fill_idx <= fill_idx + 1'b1;  // Wraps to 0 after the last word
                        rd_addr  <= rd_addr + 1'b1;
                        if (fill_idx == `PITCH_IDX_W'(`PITCH_WINDOW - 1)) begin
                            sdram_read <= 1'b0;
                            state      <= S_WAIT;
                        end
                    end
                end
                S_WAIT: begin
                    if (frame_written) begin
                        if (fits) begin
                            frame_off  <= chk_off[`PITCH_ADDR_W-1:0];
                            base       <= next_base;
                            rd_addr    <= next_base;
                            sdram_read <= 1'b1;
                            state      <= S_FILL;
                        end else begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request held with its address until the SDRAM completes it
    a_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_read && !sdram_finished |=> sdram_read && $stable(rd_addr));

    a_fill_on_read: assert property (@(posedge clk) disable iff (!arst_n)
        fill_we |-> sdram_read && sdram_finished);

endmodule

/* src/window_buffer.sv */
// One-frame stereo store with Hann windowing on the read side
// Read data comes back exactly two cycles after rd_en
// A write and a read of the same index in one cycle return the old word
`timescale 1ns/10ps
`include "pitch_config.svh"

module window_buffer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    fill_we,
    input  logic [`PITCH_IDX_W-1:0] fill_idx,
    input  pitch_pkg::sdram_word_u  fill_data,
    input  logic                    rd_en,
    input  logic [`PITCH_IDX_W-1:0] rd_idx,
    output logic                    win_valid,
    output pitch_pkg::sdram_word_u  win_data
);
    localparam int PROD_W = `PITCH_SAMPLE_W + `PITCH_COEF_W + 1;

    pitch_pkg::sdram_word_u   mem  [`PITCH_WINDOW];   // Raw frame
    logic [`PITCH_COEF_W-1:0] hann [`PITCH_WINDOW];   // Hann ROM in Q0.15

    logic                     s1_valid;
    pitch_pkg::sdram_word_u   s1_pair;
    logic [`PITCH_COEF_W-1:0] s1_coef;
    logic signed [PROD_W-1:0] prod_l;
    logic signed [PROD_W-1:0] prod_r;

    for (genvar g = 0; g < `PITCH_WINDOW; g++) begin : g_rom
        assign hann[g] = pitch_pkg::hann_coeff(g);
    end

    // Coefficient zero-extended so the product stays signed
    assign prod_l = s1_pair.pair.left  * $signed({1'b0, s1_coef});
    assign prod_r = s1_pair.pair.right * $signed({1'b0, s1_coef});

    always_ff @(posedge clk) begin
        if (fill_we) begin
            mem[fill_idx] <= fill_data;
        end
        s1_pair <= mem[rd_idx];    // Stage one
        s1_coef <= hann[rd_idx];
        // Stage two keeps product >>> 15 in 16 bits
        win_data.pair.left  <= prod_l[`PITCH_SAMPLE_W+`PITCH_COEF_W-2:`PITCH_COEF_W-1];
        win_data.pair.right <= prod_r[`PITCH_SAMPLE_W+`PITCH_COEF_W-2:`PITCH_COEF_W-1];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            s1_valid  <= rd_en;
            win_valid <= s1_valid;
        end
    end

    // A frame is never refilled while it is being read
    a_no_fill_on_read: assert property (@(posedge clk) disable iff (!arst_n)
        !(fill_we && rd_en));

endmodule

/* src/overlap_add_writer.sv */
// Overlap-add consumer, one output word per windowed pair
// Output words go to dst + k*PITCH_HOP + i with 16-bit wrapping sums
// The tail half of the last frame is never written out
`timescale 1ns/10ps
`include "pitch_config.svh"

module overlap_add_writer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic [`PITCH_ADDR_W-1:0] dst_addr,
    input  logic                     frame_full,
    input  logic [`PITCH_ADDR_W-1:0] rd_addr,
    input  logic                     win_valid,
    input  pitch_pkg::sdram_word_u   win_data,
    input  logic                     sdram_finished,
    output logic                     rd_en,
    output logic [`PITCH_IDX_W-1:0]  rd_idx,
    output logic                     frame_written,
    output logic                     sdram_write,
    output logic [`PITCH_ADDR_W-1:0] sdram_addr,
    output pitch_pkg::sdram_word_u   sdram_writedata
);
    localparam int POS_W = `PITCH_IDX_W - 1;   // Index within one hop

    typedef enum logic [2:0] {S_IDLE, S_RD_LO, S_RD_HI, S_SUM, S_KEEP, S_WR} state_t;
    state_t state;

    pitch_pkg::sdram_word_u   ovl [`PITCH_HOP];   // Second half of the previous frame
    pitch_pkg::sdram_word_u   ovl_q;
    logic [POS_W-1:0]         pos;                // i
    logic                     first;              // Frame 0 treats the store as cleared
    logic [`PITCH_ADDR_W-1:0] out_addr;           // dst + k*HOP + i

    assign rd_en      = (state == S_RD_LO) || (state == S_RD_HI);
    assign rd_idx     = {state == S_RD_HI, pos};  // i then i + HOP
    assign ovl_q      = first ? '0 : ovl[pos];
    assign sdram_addr = sdram_write ? out_addr : rd_addr;   // Reader owns it otherwise

    // Output word and overlap store
    always_ff @(posedge clk) begin
        if (state == S_SUM && win_valid) begin
            sdram_writedata.pair.left  <= win_data.pair.left  + ovl_q.pair.left;
            sdram_writedata.pair.right <= win_data.pair.right + ovl_q.pair.right;
        end
        if (state == S_KEEP && win_valid) begin
            ovl[pos] <= win_data;        // Read of ovl[i] happened a cycle before
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= S_IDLE;
            pos           <= '0;
            first         <= 1'b1;
            out_addr      <= '0;
            sdram_write   <= 1'b0;
            frame_written <= 1'b0;
        end else begin
            frame_written <= 1'b0;
            if (start) begin
                state       <= S_IDLE;  // New run clears overlap and frame count
                first       <= 1'b1;
                out_addr    <= dst_addr;
                sdram_write <= 1'b0;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (frame_full) begin
                            pos   <= '0;
                            state <= S_RD_LO;
                        end
                    end
                    S_RD_LO: state <= S_RD_HI;
                    S_RD_HI: state <= S_SUM;
                    S_SUM: begin
                        if (win_valid) begin
                            state <= S_KEEP;     // First half pair summed
                        end
                    end
                    S_KEEP: begin
                        if (win_valid) begin
                            sdram_write <= 1'b1;
                            state       <= S_WR;
                        end
                    end
                    S_WR: begin
                        if (sdram_finished) begin
                            sdram_write <= 1'b0;
                            out_addr    <= out_addr + 1'b1;
                            pos         <= pos + 1'b1;
                            if (pos == '1) begin
                                frame_written <= 1'b1;   // Last word of this hop
                                first         <= 1'b0;
                                state         <= S_IDLE;
                            end else begin
                                state <= S_RD_LO;
                            end
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    a_wr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_write && !sdram_finished |=>
            sdram_write && $stable(sdram_writedata) && $stable(sdram_addr));

endmodule

/* src/pitch_core.sv */
// Time-stretch top level with frames of PITCH_WINDOW at synthesis hop PITCH_HOP
// The SDRAM side holds each strobe until sdram_finished
// Read and write strobes are never high together
`timescale 1ns/10ps
`include "pitch_config.svh"

module pitch_core (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic [`PITCH_ADDR_W-1:0]  src_addr,
    input  logic [`PITCH_ADDR_W-1:0]  dst_addr,
    input  logic [`PITCH_SPEED_W-1:0] speed,
    output logic                      done,
    output logic                      sdram_read,
    output logic                      sdram_write,
    output logic [`PITCH_ADDR_W-1:0]  sdram_addr,
    output pitch_pkg::sdram_word_u    sdram_writedata,
    input  pitch_pkg::sdram_word_u    sdram_readdata,
    input  logic                      sdram_finished
);
    logic [`PITCH_ADDR_W-1:0] rd_addr;      // Reader address into the mux
    logic                     fill_we;
    logic [`PITCH_IDX_W-1:0]  fill_idx;
    pitch_pkg::sdram_word_u   fill_data;
    logic                     frame_full;
    logic                     frame_written;
    logic                     rd_en;
    logic [`PITCH_IDX_W-1:0]  rd_idx;
    logic                     win_valid;
    pitch_pkg::sdram_word_u   win_data;

    frame_reader u_reader (
        .clk            (clk),
        .arst_n         (arst_n),
        .start          (start),
        .src_addr       (src_addr),
        .speed          (speed),
        .sdram_readdata (sdram_readdata),
        .sdram_finished (sdram_finished),
        .frame_written  (frame_written),
        .sdram_read     (sdram_read),
        .rd_addr        (rd_addr),
        .fill_we        (fill_we),
        .fill_idx       (fill_idx),
        .fill_data      (fill_data),
        .frame_full     (frame_full),
        .done           (done)
    );

    window_buffer u_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .fill_we   (fill_we),
        .fill_idx  (fill_idx),
        .fill_data (fill_data),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .win_valid (win_valid),
        .win_data  (win_data)
    );

    overlap_add_writer u_writer (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (start),
        .dst_addr        (dst_addr),
        .frame_full      (frame_full),
        .rd_addr         (rd_addr),
        .win_valid       (win_valid),
        .win_data        (win_data),
        .sdram_finished  (sdram_finished),
        .rd_en           (rd_en),
        .rd_idx          (rd_idx),
        .frame_written   (frame_written),
        .sdram_write     (sdram_write),
        .sdram_addr      (sdram_addr),
        .sdram_writedata (sdram_writedata)
    );

endmodule

/* sim/tb_pitch_core.sv */
// Testbench for pitch_core with an SDRAM model of random 0 to 3 cycle latency
// Memory is 4096 words, so every case keeps its source and destination below that
// Speed 0 never ends a run and is left out of the case table
`timescale 1ns/10ps
`include "pitch_config.svh"

module tb_pitch_core;

    localparam int NUM_CASES = 7;
    localparam int MEM_WORDS = 4096;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      start;
    logic [`PITCH_ADDR_W-1:0]  src_addr;
    logic [`PITCH_ADDR_W-1:0]  dst_addr;
    logic [`PITCH_SPEED_W-1:0] speed;
    logic                      done;
    logic                      sdram_read;
    logic                      sdram_write;
    logic [`PITCH_ADDR_W-1:0]  sdram_addr;
    pitch_pkg::sdram_word_u    sdram_writedata;
    pitch_pkg::sdram_word_u    sdram_readdata;
    logic                      sdram_finished;

    // Case table columns are source, destination, length, speed and sample seed (0 for extremes)
    string       case_name [NUM_CASES] = '{"speed8_len200", "speed12_len230", "speed4_len150",
                                           "short_len40", "extreme_len160", "exact_len64",
                                           "restart_len128"};
    logic [31:0] case_tbl [NUM_CASES][5] = '{
        '{100,  1200, 200, 8,  32'h1234_5678},
        '{400,  1600, 230, 12, 32'h0bad_cafe},
        '{700,  2000, 150, 4,  32'h7e57_0001},
        '{900,  2400, 40,  8,  32'h0000_0042},
        '{1000, 2600, 160, 12, 32'h0000_0000},
        '{3500, 3700, 64,  6,  32'h3c3c_a5a5},
        '{3000, 3300, 128, 8,  32'h9999_1111}
    };

    logic [31:0] mem     [MEM_WORDS];   // SDRAM contents
    logic [31:0] exp_mem [MEM_WORDS];   // Image expected after a run
    int          hann_ref [`PITCH_WINDOW];
    logic [31:0] exp_rd_addr [$];       // Reads in the order they must come
    logic [31:0] exp_wr_addr [$];
    logic [31:0] exp_wr_data [$];
    logic [31:0] lat_state = 32'h51ff_b5b9;
    logic        busy;                  // Request accepted with finished pending
    int          wait_cnt;
    int          err_count;
    string       cur_name;

    pitch_core DUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (start),
        .src_addr        (src_addr),
        .dst_addr        (dst_addr),
        .speed           (speed),
        .done            (done),
        .sdram_read      (sdram_read),
        .sdram_write     (sdram_write),
        .sdram_addr      (sdram_addr),
        .sdram_writedata (sdram_writedata),
        .sdram_readdata  (sdram_readdata),
        .sdram_finished  (sdram_finished)
    );

    always #20 clk = ~clk;   // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Signed sample times Q0.15 coefficient with an arithmetic shift by 15
    function automatic logic [15:0] scale_sample(input logic [15:0] s, input int n);
        int p;
        p = int'($signed(s)) * hann_ref[n];
        p = p >>> 15;
        return p[15:0];
    endfunction

    function automatic logic [31:0] window_pair(input logic [31:0] w, input int n);
        return {scale_sample(w[31:16], n), scale_sample(w[15:0], n)};
    endfunction

    task automatic report_failure(input string what);
        err_count++;
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        report_failure($sformatf("MISMATCH %s %s: expected %h actual %h",
                                 cur_name, what, exp_v, act_v));
    endtask

    // Fill memory and derive the reads, writes and final image for case c
    task automatic load_case(input int c);
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] len;
        logic [31:0] smp;
        logic [31:0] cur;
        logic [31:0] prev;
        logic [31:0] w;
        int          ha;
        int          frames;
        src = case_tbl[c][0];
        dst = case_tbl[c][1];
        len = case_tbl[c][2];
        smp = case_tbl[c][4];
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = (32'(a) * 32'h9e37_79b1) ^ (32'(c) << 28);   // Odd multiplier spreads all bits
        end
        mem[src] = {9'h0a5, len[`PITCH_ADDR_W-1:0]};   // Pad bits must be ignored
        for (int j = 1; j <= len; j++) begin
            if (case_tbl[c][4] == 0) begin
                w = j[0] ? {16'h7fff, 16'h8001} : {16'h8001, 16'h7fff};
            end else begin
                smp = xorshift32(smp);
                w   = smp;
            end
            mem[src + j] = w;
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            exp_mem[a] = mem[a];
        end
        ha     = (`PITCH_HOP * case_tbl[c][3]) >> 3;
        frames = 0;
        while (frames * ha + `PITCH_WINDOW <= len) begin
            frames++;
        end
        exp_rd_addr.push_back(src);   // Header
        for (int k = 0; k < frames; k++) begin
            for (int j = 0; j < `PITCH_WINDOW; j++) begin
                exp_rd_addr.push_back(src + 1 + k * ha + j);
            end
            for (int i = 0; i < `PITCH_HOP; i++) begin
                cur  = window_pair(mem[src + 1 + k * ha + i], i);
                prev = (k == 0) ? 32'h0 :
                       window_pair(mem[src + 1 + (k - 1) * ha + i + `PITCH_HOP], i + `PITCH_HOP);
                w = {16'(cur[31:16] + prev[31:16]), 16'(cur[15:0] + prev[15:0])};  // Wraps
                exp_wr_addr.push_back(dst + k * `PITCH_HOP + i);
                exp_wr_data.push_back(w);
                exp_mem[dst + k * `PITCH_HOP + i] = w;
            end
        end
    endtask

    // One transfer checked against the expected order
    task automatic serve_request();
        logic [31:0] a;
        logic [31:0] d;
        if (sdram_write) begin
            assert (exp_wr_addr.size() > 0)
                else report_failure($sformatf("%s: SDRAM write beyond the last frame", cur_name));
            a = exp_wr_addr.pop_front();
            d = exp_wr_data.pop_front();
            assert (32'(sdram_addr) == a) else report_mismatch("write address", a, sdram_addr);
            assert (sdram_writedata == d) else report_mismatch("write data", d, sdram_writedata);
            mem[sdram_addr] = sdram_writedata;
        end else begin
            assert (exp_rd_addr.size() > 0)
                else report_failure($sformatf("%s: SDRAM read that no frame needs", cur_name));
            a = exp_rd_addr.pop_front();
            assert (32'(sdram_addr) == a) else report_mismatch("read address", a, sdram_addr);
            sdram_readdata = mem[sdram_addr];
        end
    endtask

    // SDRAM model answering after 0 to 3 cycles
    always @(posedge clk) begin
        #2;
        if (arst_n) begin
            if (sdram_finished) begin
                sdram_finished = 1'b0;   // Transfer closed at this edge
                busy           = 1'b0;
            end
            assert (!(sdram_read && sdram_write))
                else report_failure("sdram_read and sdram_write high in the same cycle");
            if (!busy && (sdram_read || sdram_write)) begin
                busy      = 1'b1;
                lat_state = xorshift32(lat_state);
                wait_cnt  = lat_state % 4;
            end
            if (busy) begin
                if (wait_cnt == 0) begin
                    serve_request();
                    sdram_finished = 1'b1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    task automatic run_case(input int c);
        cur_name = case_name[c];
        load_case(c);
        @(posedge clk);
        #2;
        src_addr = case_tbl[c][0][`PITCH_ADDR_W-1:0];
        dst_addr = case_tbl[c][1][`PITCH_ADDR_W-1:0];
        speed    = case_tbl[c][3][`PITCH_SPEED_W-1:0];
        start    = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        assert (sdram_read)
            else report_failure($sformatf("%s: no header read one cycle after start", cur_name));
        while (!done) begin   // Poll once per cycle
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        assert (!done) else report_failure($sformatf("%s: done longer than a cycle", cur_name));
        assert (!sdram_read && !sdram_write)
            else report_failure($sformatf("%s: SDRAM strobe still high after done", cur_name));
        assert (exp_rd_addr.size() == 0 && exp_wr_addr.size() == 0)
            else report_failure($sformatf("%s: done with %0d reads and %0d writes missing",
                                          cur_name, exp_rd_addr.size(), exp_wr_addr.size()));
        for (int a = 0; a < MEM_WORDS; a++) begin
            assert (mem[a] == exp_mem[a])
                else report_mismatch($sformatf("memory word %0d", a), exp_mem[a], mem[a]);
        end
        $display("case %s finished", cur_name);
    endtask

    initial begin
        real w;
        arst_n         = 1'b0;
        start          = 1'b0;
        src_addr       = '0;
        dst_addr       = '0;
        speed          = '0;
        sdram_readdata = '0;
        sdram_finished = 1'b0;
        busy           = 1'b0;
        wait_cnt       = 0;
        err_count      = 0;
        for (int n = 0; n < `PITCH_WINDOW; n++) begin
            w = 0.5 - 0.5 * $cos(2.0 * 3.14159265358979 * n / `PITCH_WINDOW);
            hann_ref[n] = $rtoi(w * 32768.0 + 0.5);
            if (hann_ref[n] > 32767) begin
                hann_ref[n] = 32767;   // Q0.15 top
            end
        end
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);   // Each start after the first also checks the cleared overlap
        end
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Summed lengths x 40 cycles x 40 ns plus the reset cycles
    initial begin : watchdog
        int total;
        total = 0;
        for (int c = 0; c < NUM_CASES; c++) begin
            total += case_tbl[c][2];
        end
        #((total * 40 + 16) * 40);
        report_failure("watchdog expired before all cases reached done");
    end

endmodule

/* pitch_core.f */
+incdir+src
src/pitch_pkg.sv
src/frame_reader.sv
src/window_buffer.sv
src/overlap_add_writer.sv
src/pitch_core.sv
sim/tb_pitch_core.sv
